//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_aura_backend
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
EXE       ?= sim_$(TOP)
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(EXE)

# the run fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/$(EXE))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+tb
rtl/isa_pkg.sv
rtl/backend_pkg.sv
rtl/exe_pipe.sv
rtl/oldest_select.sv
rtl/ctrl_block.sv
rtl/aura_backend.sv
tb/tb_aura_backend.sv

//--- rtl/aura_backend.sv
`timescale 1ns/1ps
`default_nettype none

module aura_backend
    import isa_pkg::*, backend_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  wire            clk,
    input  wire            i_reset,

    input  wire            i_inst_vld,
    input  fetch_entry_t   i_inst,
    output logic           o_stall,

    output logic           o_squash_vld,
    output squash_info_t   o_squash_info,

    output logic [1:0]     o_branchwb_vld,
    output branchwb_info_t o_branchwb_info [2],

    output logic           o_commit_vld,
    output commit_info_t   o_commit_info
);
    logic [1:0]   disp_vld;
    pipe_op_t     disp_op [2];
    logic [1:0]   wb_vld;
    wb_info_t     wb_info [2];
    rob_idx_t     rob_head;

    ctrl_block #(
        .ROB_DEPTH     ( ROB_DEPTH     )
    ) u_ctrl_block (
        .clk           ( clk           ),
        .i_reset       ( i_reset       ),
        .i_inst_vld    ( i_inst_vld    ),
        .i_inst        ( i_inst        ),
        .o_stall       ( o_stall       ),
        .o_disp_vld    ( disp_vld      ),
        .o_disp_op     ( disp_op       ),
        .i_wb_vld      ( wb_vld        ),
        .i_wb_info     ( wb_info       ),
        .i_squash_vld  ( o_squash_vld  ),
        .i_squash_info ( o_squash_info ),
        .o_rob_head    ( rob_head      ),
        .o_commit_vld  ( o_commit_vld  ),
        .o_commit_info ( o_commit_info )
    );

    // ============================================================
    // execution pipes, pipe 0 has latency 1 and pipe 1 latency 2
    // ============================================================
    generate
        for (genvar p = 0; p < 2; p++) begin : gen_pipe
            exe_pipe #(
                .LATENCY       ( p + 1         ),
                .ROB_DEPTH     ( ROB_DEPTH     )
            ) u_exe_pipe (
                .clk           ( clk           ),
                .i_reset       ( i_reset       ),
                .i_op_vld      ( disp_vld[p]   ),
                .i_op          ( disp_op[p]    ),
                .i_squash_vld  ( o_squash_vld  ),
                .i_squash_info ( o_squash_info ),
                .i_rob_head    ( rob_head      ),
                .o_wb_vld      ( wb_vld[p]     ),
                .o_wb_info     ( wb_info[p]    )
            );

            assign o_branchwb_vld[p]          = wb_vld[p] && wb_info[p].is_br;
            assign o_branchwb_info[p].rob_idx = wb_info[p].rob_idx;
            assign o_branchwb_info[p].pc      = wb_info[p].result;  // branches carry pc here
            assign o_branchwb_info[p].taken   = wb_info[p].taken;
            assign o_branchwb_info[p].target  = wb_info[p].target;
        end
    endgenerate

    oldest_select #(
        .ROB_DEPTH     ( ROB_DEPTH     )
    ) u_oldest_select (
        .i_vld         ( wb_vld        ),
        .i_wb_info     ( wb_info       ),
        .i_rob_head    ( rob_head      ),
        .o_squash_vld  ( o_squash_vld  ),
        .o_squash_info ( o_squash_info )
    );

endmodule

`default_nettype wire

//--- rtl/backend_pkg.sv
`default_nettype none

package backend_pkg;
    import isa_pkg::*;

    typedef logic [3:0] rob_idx_t;  // wide enough for a 16 entry rob

    typedef struct packed {
        rob_idx_t   rob_idx;
        opcode_e    opcode;
        pc_t        pc;
        logic [7:0] imm;
        xdata_t     src1;
        xdata_t     src2;
    } pipe_op_t;

    // a branch returns its own pc in result, it never writes a register
    typedef struct packed {
        rob_idx_t rob_idx;
        xdata_t   result;
        logic     is_br;
        logic     taken;
        pc_t      target;
    } wb_info_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        pc_t      pc;
        logic     taken;
        pc_t      target;
    } branchwb_info_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        pc_t      redirect_pc;
    } squash_info_t;

    typedef struct packed {
        pc_t      pc;
        reg_idx_t rd;
        logic     wen;
        xdata_t   data;
    } commit_info_t;

    // distance of an entry from the rob head, zero is the oldest
    function automatic rob_idx_t rob_age(rob_idx_t idx, rob_idx_t head, int unsigned depth);
        return rob_idx_t'((idx - head) & rob_idx_t'(depth - 1));
    endfunction

endpackage

`default_nettype wire

//--- rtl/ctrl_block.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_block
    import isa_pkg::*, backend_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  wire             clk,
    input  wire             i_reset,

    input  wire             i_inst_vld,
    input  fetch_entry_t    i_inst,
    output logic            o_stall,

    output logic [1:0]      o_disp_vld,
    output pipe_op_t        o_disp_op [2],

    input  wire  [1:0]      i_wb_vld,
    input  wb_info_t        i_wb_info [2],

    input  wire             i_squash_vld,
    input  squash_info_t    i_squash_info,

    output rob_idx_t        o_rob_head,
    output logic            o_commit_vld,
    output commit_info_t    o_commit_info
);
    localparam int IW = $clog2(ROB_DEPTH);
    localparam rob_idx_t IDX_MASK = rob_idx_t'(ROB_DEPTH - 1);

    // ============================================================
    // rob storage and architectural registers
    // ============================================================
    logic [ROB_DEPTH-1:0] rob_vld;
    logic [ROB_DEPTH-1:0] rob_done;
    logic [ROB_DEPTH-1:0] rob_wen;
    pc_t                  rob_pc     [ROB_DEPTH];
    reg_idx_t             rob_rd     [ROB_DEPTH];
    xdata_t               rob_result [ROB_DEPTH];
    xdata_t               regfile    [8];

    rob_idx_t             head;
    rob_idx_t             tail;
    logic [IW-1:0]        head_slot;
    logic [IW-1:0]        tail_slot;

    logic                 rob_full;
    logic                 hazard;
    logic                 accept;
    logic                 commit_fire;
    rob_idx_t             br_age;
    logic [ROB_DEPTH-1:0] younger_mask;
    pipe_op_t             disp_op;

    assign head_slot   = head[IW-1:0];
    assign tail_slot   = tail[IW-1:0];
    assign rob_full    = rob_vld[tail_slot];  // tail still busy means the ring wrapped
    assign commit_fire = rob_vld[head_slot] && rob_done[head_slot];
    assign o_rob_head  = head;

    // scoreboard rebuilt from live entries every cycle
    always_comb begin
        hazard = 1'b0;
        for (int e = 0; e < ROB_DEPTH; e++) begin
            if (rob_vld[e] && rob_wen[e]) begin
                if (rob_rd[e] == i_inst.rs1) hazard = 1'b1;
                if (i_inst.opcode != OP_ADDI && rob_rd[e] == i_inst.rs2) hazard = 1'b1;
            end
        end
    end

    assign o_stall = rob_full || (i_inst_vld && hazard);
    assign accept  = i_inst_vld && !o_stall && !i_squash_vld;

    always_comb begin
        disp_op.rob_idx = tail;
        disp_op.opcode  = i_inst.opcode;
        disp_op.pc      = i_inst.pc;
        disp_op.imm     = i_inst.imm;
        disp_op.src1    = regfile[i_inst.rs1];
        disp_op.src2    = regfile[i_inst.rs2];
        o_disp_op[0]    = disp_op;
        o_disp_op[1]    = disp_op;
        o_disp_vld[0]   = accept && !tail[0];  // even slots go to the short pipe
        o_disp_vld[1]   = accept && tail[0];
    end

    // entries behind the squashing branch are dropped
    always_comb begin
        br_age = rob_age(i_squash_info.rob_idx, head, ROB_DEPTH);
        for (int e = 0; e < ROB_DEPTH; e++) begin
            younger_mask[e] = rob_age(rob_idx_t'(e), head, ROB_DEPTH) > br_age;
        end
    end

    // ============================================================
    // control state
    // ============================================================
    always_ff @(posedge clk) begin
        if (i_reset) begin
            rob_vld      <= '0;
            rob_done     <= '0;
            head         <= '0;
            tail         <= '0;
            o_commit_vld <= 1'b0;
            for (int r = 0; r < 8; r++) begin
                regfile[r] <= '0;
            end
        end else begin
            o_commit_vld <= commit_fire;
            if (accept) begin
                rob_vld[tail_slot]  <= 1'b1;
                rob_done[tail_slot] <= 1'b0;
                tail                <= (tail + rob_idx_t'(1)) & IDX_MASK;
            end
            for (int l = 0; l < 2; l++) begin
                if (i_wb_vld[l]) rob_done[i_wb_info[l].rob_idx[IW-1:0]] <= 1'b1;
            end
            if (commit_fire) begin
                rob_vld[head_slot] <= 1'b0;
                head               <= (head + rob_idx_t'(1)) & IDX_MASK;
                if (rob_wen[head_slot]) regfile[rob_rd[head_slot]] <= rob_result[head_slot];
            end
            if (i_squash_vld) begin
                for (int e = 0; e < ROB_DEPTH; e++) begin
                    if (younger_mask[e]) rob_vld[e] <= 1'b0;
                end
                tail <= (i_squash_info.rob_idx + rob_idx_t'(1)) & IDX_MASK;
            end
        end
    end

    // payload, only meaningful while the matching valid bit is set
    always_ff @(posedge clk) begin
        if (accept) begin
            rob_pc[tail_slot]  <= i_inst.pc;
            rob_rd[tail_slot]  <= i_inst.rd;
            rob_wen[tail_slot] <= !is_branch(i_inst.opcode);
        end
        for (int l = 0; l < 2; l++) begin
            if (i_wb_vld[l]) rob_result[i_wb_info[l].rob_idx[IW-1:0]] <= i_wb_info[l].result;
        end
        o_commit_info.pc   <= rob_pc[head_slot];
        o_commit_info.rd   <= rob_rd[head_slot];
        o_commit_info.wen  <= rob_wen[head_slot];
        o_commit_info.data <= rob_result[head_slot];
    end

endmodule

`default_nettype wire

//--- rtl/exe_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module exe_pipe
    import isa_pkg::*, backend_pkg::*;
#(
    parameter int LATENCY   = 1,
    parameter int ROB_DEPTH = 8
) (
    input  wire          clk,
    input  wire          i_reset,

    input  wire          i_op_vld,
    input  pipe_op_t     i_op,

    input  wire          i_squash_vld,
    input  squash_info_t i_squash_info,
    input  rob_idx_t     i_rob_head,

    output logic         o_wb_vld,
    output wb_info_t     o_wb_info
);
    xdata_t             imm_ext;
    xdata_t             opnd_b;
    wb_info_t           wb_next;
    rob_idx_t           br_age;
    logic [LATENCY-1:0] stg_vld;
    logic [LATENCY-1:0] stg_kill;
    wb_info_t           stg_info [LATENCY];

    // ============================================================
    // alu and branch resolve
    // ============================================================
    always_comb begin
        imm_ext         = {{8{i_op.imm[7]}}, i_op.imm};
        opnd_b          = (i_op.opcode == OP_ADDI) ? imm_ext : i_op.src2;
        wb_next         = '0;
        wb_next.rob_idx = i_op.rob_idx;
        wb_next.target  = i_op.pc + imm_ext;  // not-taken was predicted, so only taken redirects
        case (i_op.opcode)
            OP_ADD, OP_ADDI: wb_next.result = i_op.src1 + opnd_b;
            OP_SUB:          wb_next.result = i_op.src1 - opnd_b;
            OP_XOR:          wb_next.result = i_op.src1 ^ opnd_b;
            OP_BEQ: begin
                wb_next.is_br  = 1'b1;
                wb_next.taken  = (i_op.src1 == i_op.src2);
                wb_next.result = i_op.pc;
            end
            OP_BNE: begin
                wb_next.is_br  = 1'b1;
                wb_next.taken  = (i_op.src1 != i_op.src2);
                wb_next.result = i_op.pc;
            end
            default: wb_next.result = '0;
        endcase
    end

    // an op entering stage s dies if it is younger than the squashing branch
    always_comb begin
        br_age      = rob_age(i_squash_info.rob_idx, i_rob_head, ROB_DEPTH);
        stg_kill[0] = i_squash_vld && (rob_age(i_op.rob_idx, i_rob_head, ROB_DEPTH) > br_age);
        for (int s = 1; s < LATENCY; s++) begin
            stg_kill[s] = i_squash_vld &&
                          (rob_age(stg_info[s-1].rob_idx, i_rob_head, ROB_DEPTH) > br_age);
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            stg_vld <= '0;
        end else begin
            stg_vld[0] <= i_op_vld && !stg_kill[0];
            for (int s = 1; s < LATENCY; s++) begin
                stg_vld[s] <= stg_vld[s-1] && !stg_kill[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        stg_info[0] <= wb_next;
        for (int s = 1; s < LATENCY; s++) begin
            stg_info[s] <= stg_info[s-1];
        end
    end

    assign o_wb_vld  = stg_vld[LATENCY-1];
    assign o_wb_info = stg_info[LATENCY-1];

endmodule

`default_nettype wire

//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // ============================================================
    // instruction set
    // ============================================================
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_XOR  = 3'd2,
        OP_ADDI = 3'd3,
        OP_BEQ  = 3'd4,
        OP_BNE  = 3'd5
    } opcode_e;

    typedef logic [2:0]  reg_idx_t;
    typedef logic [15:0] xdata_t;
    typedef logic [15:0] pc_t;

    // ADDI reads rs1 and imm, branches compare rs1 with rs2 and jump by imm
    typedef struct packed {
        pc_t      pc;
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic [7:0] imm;
    } fetch_entry_t;

    function automatic logic is_branch(opcode_e op);
        return (op == OP_BEQ) || (op == OP_BNE);
    endfunction

endpackage

`default_nettype wire

//--- rtl/oldest_select.sv
`timescale 1ns/1ps
`default_nettype none

module oldest_select
    import backend_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  wire  [1:0]    i_vld,
    input  wb_info_t      i_wb_info [2],
    input  rob_idx_t      i_rob_head,
    output logic          o_squash_vld,
    output squash_info_t  o_squash_info
);
    logic [1:0] cand;
    rob_idx_t   age0;
    rob_idx_t   age1;
    logic       pick1;

    always_comb begin
        cand[0] = i_vld[0] && i_wb_info[0].taken;  // taken is only ever set on branches
        cand[1] = i_vld[1] && i_wb_info[1].taken;
        age0    = rob_age(i_wb_info[0].rob_idx, i_rob_head, ROB_DEPTH);
        age1    = rob_age(i_wb_info[1].rob_idx, i_rob_head, ROB_DEPTH);

        // two live entries never share an age
        pick1 = cand[1] && (!cand[0] || (age1 < age0));

        o_squash_vld = |cand;
        o_squash_info.rob_idx     = pick1 ? i_wb_info[1].rob_idx : i_wb_info[0].rob_idx;
        o_squash_info.redirect_pc = pick1 ? i_wb_info[1].target  : i_wb_info[0].target;
    end

endmodule

`default_nettype wire

//--- tb/backend_ref_model.svh
`ifndef BACKEND_REF_MODEL_SVH
`define BACKEND_REF_MODEL_SVH

// architectural model, runs the program one instruction per step from pc 0
// and returns the number of expected commits
function automatic int ref_execute(input fetch_entry_t prog [PROG_MAX],
                                   input int prog_len,
                                   input int max_steps,
                                   output commit_info_t exp [PROG_MAX],
                                   output int n_branch);
    xdata_t       regs [8];
    xdata_t       imm_ext;
    xdata_t       a;
    xdata_t       b;
    pc_t          pc;
    fetch_entry_t in;
    logic         taken;
    int           n;

    for (int r = 0; r < 8; r++) begin
        regs[r] = '0;
    end
    pc       = '0;
    n        = 0;
    n_branch = 0;
    while (int'(pc) < prog_len && n < max_steps) begin
        in          = prog[pc[7:0]];
        imm_ext     = {{8{in.imm[7]}}, in.imm};
        a           = regs[in.rs1];
        b           = regs[in.rs2];
        taken       = 1'b0;
        exp[n].pc   = pc;
        exp[n].rd   = in.rd;
        exp[n].wen  = 1'b1;
        exp[n].data = '0;
        case (in.opcode)
            OP_ADD:  exp[n].data = a + b;
            OP_SUB:  exp[n].data = a - b;
            OP_XOR:  exp[n].data = a ^ b;
            OP_ADDI: exp[n].data = a + imm_ext;
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            default: exp[n].data = '0;
        endcase
        if (in.opcode == OP_BEQ || in.opcode == OP_BNE) begin
            exp[n].wen = 1'b0;  // branches retire without a register write
            n_branch++;
        end else begin
            regs[in.rd] = exp[n].data;
        end
        pc = taken ? pc + imm_ext : pc + 16'd1;
        n++;
    end
    return n;
endfunction

`endif

//--- tb/tb_aura_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aura_backend
    import isa_pkg::*, backend_pkg::*;
();
    localparam int ROB_DEPTH  = 8;
    localparam int PROG_MAX   = 256;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT    = 3000;

    logic           clk;
    logic           i_reset;
    logic           i_inst_vld;
    fetch_entry_t   i_inst;
    logic           o_stall;
    logic           o_squash_vld;
    squash_info_t   o_squash_info;
    logic [1:0]     o_branchwb_vld;
    branchwb_info_t o_branchwb_info [2];
    logic           o_commit_vld;
    commit_info_t   o_commit_info;

    fetch_entry_t   program_mem [PROG_MAX];
    commit_info_t   exp_list    [PROG_MAX];
    int             prog_len;
    int             exp_count;
    int             exp_branches;
    int             commit_count;
    int             branch_beats;
    int             dual_beats;
    int             stall_cycles;
    int             error_count;
    int             test_errors;
    int             tests_run;
    int             tests_failed;
    logic           running;
    pc_t            fetch_pc;

    `include "backend_ref_model.svh"

    aura_backend #(
        .ROB_DEPTH       ( ROB_DEPTH       )
    ) UUT (
        .clk             ( clk             ),
        .i_reset         ( i_reset         ),
        .i_inst_vld      ( i_inst_vld      ),
        .i_inst          ( i_inst          ),
        .o_stall         ( o_stall         ),
        .o_squash_vld    ( o_squash_vld    ),
        .o_squash_info   ( o_squash_info   ),
        .o_branchwb_vld  ( o_branchwb_vld  ),
        .o_branchwb_info ( o_branchwb_info ),
        .o_commit_vld    ( o_commit_vld    ),
        .o_commit_info   ( o_commit_info   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // checking helpers
    // ============================================================
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_quiet(input string when_txt);
        check_value({"o_commit_vld ", when_txt}, 32'(o_commit_vld), 32'd0);
        check_value({"o_squash_vld ", when_txt}, 32'(o_squash_vld), 32'd0);
        check_value({"o_branchwb_vld ", when_txt}, 32'(o_branchwb_vld), 32'd0);
        check_value({"o_stall ", when_txt}, 32'(o_stall), 32'd0);
    endtask

    // a branch writeback names a program branch, its own lane and the pc relative target
    task automatic inspect_branch_wb(input int lane);
        branchwb_info_t bw;
        fetch_entry_t   src;
        pc_t            want_target;
        bw          = o_branchwb_info[lane];
        src         = program_mem[bw.pc[7:0]];
        want_target = bw.pc + {{8{src.imm[7]}}, src.imm};
        check_value("branch writeback pc in program", 32'(int'(bw.pc) < prog_len), 32'd1);
        check_value("branch writeback opcode is a branch",
                    32'(src.opcode == OP_BEQ || src.opcode == OP_BNE), 32'd1);
        check_value("branch writeback rob parity", 32'(bw.rob_idx[0]), 32'(lane));
        check_value("branch writeback target", 32'(bw.target), 32'(want_target));
        if (bw.taken) check_value("squash on taken branch", 32'(o_squash_vld), 32'd1);
    endtask

    // fetch side, decisions use values sampled mid-cycle where they are settled
    initial begin : fetch_model
        logic acc;
        logic redirect;
        logic active;
        pc_t  redirect_pc;
        forever begin
            @(negedge clk);
            active      = running && !i_reset;
            acc         = i_inst_vld && !o_stall && !o_squash_vld;
            redirect    = o_squash_vld;
            redirect_pc = o_squash_info.redirect_pc;
            if (active && i_inst_vld && o_stall && !o_squash_vld) stall_cycles++;
            @(posedge clk);
            #2;
            if (!active) begin
                fetch_pc = '0;
            end else if (redirect) begin
                fetch_pc = redirect_pc;  // presented instruction was dropped in the squash cycle
            end else if (acc) begin
                fetch_pc = fetch_pc + 16'd1;
            end
            if (active && int'(fetch_pc) < prog_len) begin
                i_inst_vld = 1'b1;
                i_inst     = program_mem[fetch_pc[7:0]];
            end else begin
                i_inst_vld = 1'b0;
            end
        end
    end

    // every commit beat is matched against the next entry of the model trace
    initial begin : commit_monitor
        logic hit;
        forever begin
            @(negedge clk);
            if (!i_reset && o_commit_vld) begin
                if (commit_count < exp_count) begin
                    check_value("commit pc", 32'(o_commit_info.pc),
                                32'(exp_list[commit_count].pc));
                    check_value("commit wen", 32'(o_commit_info.wen),
                                32'(exp_list[commit_count].wen));
                    if (exp_list[commit_count].wen) begin
                        check_value("commit rd", 32'(o_commit_info.rd),
                                    32'(exp_list[commit_count].rd));
                        check_value("commit data", 32'(o_commit_info.data),
                                    32'(exp_list[commit_count].data));
                    end
                end else begin
                    $display("[ERROR] %0t: commit of pc %0h after the last expected commit",
                             $time, o_commit_info.pc);
                    error_count++;
                    test_errors++;
                end
                commit_count++;
            end
            if (!i_reset) begin
                branch_beats += int'(o_branchwb_vld[0]) + int'(o_branchwb_vld[1]);
                if (o_branchwb_vld == 2'b11) dual_beats++;
                for (int l = 0; l < 2; l++) begin
                    if (o_branchwb_vld[l]) inspect_branch_wb(l);
                end
                if (o_squash_vld) begin
                    hit = 1'b0;
                    for (int l = 0; l < 2; l++) begin
                        if (o_branchwb_vld[l] && o_branchwb_info[l].taken &&
                            o_branchwb_info[l].rob_idx == o_squash_info.rob_idx &&
                            o_branchwb_info[l].target == o_squash_info.redirect_pc) begin
                            hit = 1'b1;
                        end
                    end
                    check_value("squash matches a taken branch writeback", 32'(hit), 32'd1);
                end
            end
        end
    end

    // ============================================================
    // sequencing
    // ============================================================
    task automatic wait_cycles(input int n);
        for (int c = 0; c < n; c++) begin
            @(posedge clk);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        i_reset      = 1'b1;
        running      = 1'b0;
        test_errors  = 0;
        commit_count = 0;
        branch_beats = 0;
        dual_beats   = 0;
        stall_cycles = 0;
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            if (c > 0) check_quiet("during reset");  // first edge has not reset the state yet
            @(posedge clk);
        end
        #2;
        i_reset = 1'b0;
        running = 1'b1;
        @(negedge clk);
        check_quiet("after reset");
    endtask

    task automatic wait_for_commits(input int limit);
        int cycles;
        cycles = 0;
        while (commit_count < exp_count && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (commit_count < exp_count) begin
            $display("timeout waiting for commit %0d of %0d", commit_count + 1, exp_count);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic add_inst(input opcode_e op, input int rd, input int rs1, input int rs2,
                            input int imm);
        fetch_entry_t inst;
        inst.pc     = pc_t'(prog_len);
        inst.opcode = op;
        inst.rd     = reg_idx_t'(rd);
        inst.rs1    = reg_idx_t'(rs1);
        inst.rs2    = reg_idx_t'(rs2);
        inst.imm    = 8'(imm);
        program_mem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic build_random_program(input int count);
        int op;
        int imm;
        prog_len = 0;
        for (int i = 0; i < count; i++) begin
            op = int'($urandom_range(5, 0));
            if (op >= 4) begin
                imm = int'($urandom_range(6, 1));  // forward branches only
            end else begin
                imm = int'($urandom_range(255, 0));
            end
            add_inst(opcode_e'(3'(op)), int'($urandom_range(7, 0)),
                     int'($urandom_range(7, 0)), int'($urandom_range(7, 0)), imm);
        end
    endtask

    task automatic run_program();
        exp_count = ref_execute(program_mem, prog_len, PROG_MAX, exp_list, exp_branches);
        apply_reset();
        wait_for_commits(TIMEOUT);
        @(posedge clk);
        #2;
        running = 1'b0;
        wait_cycles(4);
        if (branch_beats < exp_branches) begin
            $display("[ERROR] %0t: %0d branch writebacks for %0d retired branches",
                     $time, branch_beats, exp_branches);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %0s: %0s, %0d commits, %0d branch writebacks, %0d stall cycles",
                 name, (test_errors == 0) ? "pass" : "fail",
                 commit_count, branch_beats, stall_cycles);
    endtask

    initial begin
        i_reset      = 1'b1;
        i_inst_vld   = 1'b0;
        i_inst       = '0;
        running      = 1'b0;
        fetch_pc     = '0;
        prog_len     = 0;
        exp_count    = 0;
        exp_branches = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(19));

        apply_reset();
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_quiet("while idle");
        end
        finish_test("reset");

        // dependent chain, each op reads a result that is still in flight
        prog_len = 0;
        add_inst(OP_ADDI, 1, 0, 0, 7);
        add_inst(OP_ADDI, 2, 1, 0, 5);
        add_inst(OP_ADD,  3, 1, 2, 0);
        add_inst(OP_SUB,  4, 3, 1, 0);
        add_inst(OP_XOR,  5, 4, 2, 0);
        add_inst(OP_ADDI, 0, 5, 0, -3);
        add_inst(OP_ADD,  6, 0, 5, 0);
        add_inst(OP_SUB,  7, 6, 3, 0);
        run_program();
        finish_test("arithmetic");

        prog_len = 0;
        add_inst(OP_ADDI, 1, 0, 0, 3);
        add_inst(OP_ADDI, 2, 0, 0, 3);
        add_inst(OP_BEQ,  0, 1, 2, 4);
        add_inst(OP_ADDI, 3, 0, 0, 1);  // pc 3 to 5 are the wrong path
        add_inst(OP_ADD,  4, 1, 1, 0);
        add_inst(OP_XOR,  5, 1, 2, 0);
        add_inst(OP_SUB,  6, 1, 2, 0);
        add_inst(OP_ADDI, 7, 6, 0, -1);
        add_inst(OP_BNE,  0, 1, 2, 2);
        add_inst(OP_ADD,  1, 7, 2, 0);
        run_program();
        finish_test("taken branch");

        // branch at pc 1 lands on odd slot 1, the one at pc 2 on even slot 2
        prog_len = 0;
        add_inst(OP_ADDI, 1, 0, 0, 5);
        add_inst(OP_BEQ,  0, 2, 3, 4);
        add_inst(OP_BEQ,  0, 4, 5, 6);
        add_inst(OP_ADDI, 6, 0, 0, 1);
        add_inst(OP_ADDI, 7, 0, 0, 2);
        add_inst(OP_ADDI, 2, 1, 0, 3);
        add_inst(OP_XOR,  3, 2, 1, 0);
        add_inst(OP_ADDI, 4, 0, 0, 9);
        add_inst(OP_ADDI, 5, 0, 0, 7);
        run_program();
        check_value("same cycle branch writebacks", 32'(dual_beats > 0), 32'd1);
        finish_test("same cycle branches");

        prog_len = 0;
        for (int i = 0; i < 40; i++) begin
            add_inst(OP_ADDI, (i % 7) + 1, 0, 0, i);
        end
        add_inst(OP_ADD, 1, 2, 3, 0);
        add_inst(OP_SUB, 4, 1, 5, 0);
        run_program();
        finish_test("rob pressure");

        build_random_program(200);
        run_program();
        finish_test("random program");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
